// File: src/icache_pkg.sv
/* Instruction cache shared definitions
   Holds the cache geometry, the controller state codes and the fetch address layout */

package icache_pkg;

	// ============================================================
	// Cache geometry
	// ============================================================

	localparam int awid           = 32;
	localparam int ways           = 4;
	localparam int lines          = 128;
	localparam int words_per_line = 16;
	localparam int tag_bits       = 19;
	localparam int index_bits     = 7;
	localparam int word_bits      = 4;
	localparam int way_bits       = 2;

	// Refill controller state codes
	localparam int state_bits = 3;
	localparam logic [state_bits-1:0] st_idle     = 3'd0;
	localparam logic [state_bits-1:0] st_compare  = 3'd1;
	localparam logic [state_bits-1:0] st_qualify  = 3'd2;
	localparam logic [state_bits-1:0] st_read     = 3'd3;
	localparam logic [state_bits-1:0] st_request  = 3'd4;
	localparam logic [state_bits-1:0] st_fill     = 3'd5;
	localparam logic [state_bits-1:0] st_install  = 3'd6;
	localparam logic [state_bits-1:0] st_relookup = 3'd7;

	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [way_bits-1:0] way_t;

	// The fetch address is seen either as a flat byte address
	// or split into tag, set index, word in line and byte lane
	typedef union packed {
		logic [awid-1:0] raw;
		struct packed {
			tag_t                  tag;
			logic [index_bits-1:0] index;
			logic [word_bits-1:0]  word;
			logic [1:0]            byte_sel;
		} fields;
	} fetch_addr_t;

endpackage

// File: src/icache_tag_ram.sv
/* Instruction cache tag store
   Tags and valid bits for four ways of 128 sets, with refill write and global invalidate */

`timescale 1ns/1ps

module icache_tag_ram (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              invalidate,
	input  logic                              tag_we,
	input  icache_pkg::way_t                  tag_way,
	input  logic [icache_pkg::index_bits-1:0] tag_index,
	input  icache_pkg::tag_t                  tag_value,
	output icache_pkg::tag_t                  tags [0:icache_pkg::ways-1][0:icache_pkg::lines-1],
	output logic [icache_pkg::lines-1:0]      valid [0:icache_pkg::ways-1]
);

	import icache_pkg::*;

	// ============================================================
	// Tag array
	// ============================================================

	// The tags are plain storage and are only meaningful where
	// the matching valid bit is set
	// A refill writes exactly one tag of one way per install
	always_ff @(posedge clk)
	begin
		if (tag_we)
		begin
			tags[tag_way][tag_index] <= tag_value;
		end
	end

	// ============================================================
	// Valid bits
	// ============================================================

	// Every valid bit drops on reset or on a global invalidate
	// The invalidate wins over a refill install on the same edge
	// An install marks its line valid on the same edge the tag is written,
	// so the tag and its valid bit are never seen apart
	always_ff @(posedge clk)
	begin
		if (reset || invalidate)
		begin
			for (int w = 0; w < ways; w++)
			begin
				valid[w] <= '0;
			end
		end
		else if (tag_we)
		begin
			valid[tag_way][tag_index] <= 1'b1;
		end
	end

	// The arrays are read combinationally by the hit detector,
	// which indexes them by the set of the latched lookup address
	// Nothing here ever clears a single line, only the whole cache
	// Replacement simply overwrites the tag and keeps the valid bit set

endmodule

// File: src/icache_hit_detect.sv
/* Instruction cache hit detector
   Compares the lookup tag with four ways, qualifies the hit over two cycles, reads the victim */

`timescale 1ns/1ps

module icache_hit_detect (
	input  logic                         clk,
	input  logic                         reset,
	input  icache_pkg::fetch_addr_t      lookup_addr,
	input  icache_pkg::tag_t             tags [0:icache_pkg::ways-1][0:icache_pkg::lines-1],
	input  logic [icache_pkg::lines-1:0] valid [0:icache_pkg::ways-1],
	input  icache_pkg::way_t             victim_way,
	output logic                         ihit,
	output icache_pkg::way_t             hit_way,
	output icache_pkg::tag_t             victim_tag,
	output logic                         victim_valid
);

	import icache_pkg::*;

	// Per-way match of the current lookup
	logic [ways-1:0] match;
	// First stage of the hit qualification
	logic            hit_q1;
	// Way reported on the previous cycle
	way_t            prev_way;

	// ============================================================
	// Tag compare
	// ============================================================

	// Each way matches only when its line in the addressed set is valid
	// and holds the same tag as the lookup address
	always_comb
	begin
		for (int w = 0; w < ways; w++)
		begin
			match[w] = valid[w][lookup_addr.fields.index] &&
				(tags[w][lookup_addr.fields.index] == lookup_addr.fields.tag);
		end
	end

	// The highest matching way wins
	// With no match the way of the last cycle is held, so the data
	// store keeps reading a stable location between lookups
	always_comb
	begin
		hit_way = prev_way;
		for (int w = 0; w < ways; w++)
		begin
			if (match[w])
			begin
				hit_way = way_t'(w);
			end
		end
	end

	// ============================================================
	// Hit qualification
	// ============================================================

	// A hit is reported only when the compare matched in two cycles
	// in a row, which keeps a fresh address or a tag written one edge
	// earlier from being reported as a hit too soon
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			prev_way <= '0;
			hit_q1   <= 1'b0;
			ihit     <= 1'b0;
		end
		else
		begin
			prev_way <= hit_way;
			hit_q1   <= |match;
			ihit     <= hit_q1 & (|match);
		end
	end

	// Replacement candidate of the addressed set, for the eviction report
	assign victim_tag   = tags[victim_way][lookup_addr.fields.index];
	assign victim_valid = valid[victim_way][lookup_addr.fields.index];

endmodule

// File: src/icache_data_ram.sv
/* Instruction cache data store
   Line data for four ways with one refill beat written and one word read per cycle */

`timescale 1ns/1ps

module icache_data_ram (
	input  logic                              clk,
	input  logic                              data_we,
	input  icache_pkg::way_t                  data_way,
	input  logic [icache_pkg::index_bits-1:0] data_index,
	input  logic [icache_pkg::word_bits-1:0]  data_word,
	input  logic [31:0]                       wdata,
	input  icache_pkg::fetch_addr_t           lookup_addr,
	input  icache_pkg::way_t                  hit_way,
	output logic [31:0]                       rdata
);

	import icache_pkg::*;

	// 8192 instruction words organized by way, set and word in line
	logic [31:0] mem [0:ways-1][0:lines-1][0:words_per_line-1];

	// ============================================================
	// Refill write port
	// ============================================================

	// Each beat from memory lands in the way chosen by the controller,
	// at the word position counted by its beat counter
	always_ff @(posedge clk)
	begin
		if (data_we)
		begin
			mem[data_way][data_index][data_word] <= wdata;
		end
	end

	// ============================================================
	// Fetch read port
	// ============================================================

	// The word is read every cycle from the lookup address in the way
	// named by the detector
	// Once the address and way are stable the output follows one edge later
	// The controller samples it only after the hit is qualified
	always_ff @(posedge clk)
	begin
		rdata <= mem[hit_way][lookup_addr.fields.index][lookup_addr.fields.word];
	end

	// There is no bypass from the write port to the read port
	// A refilled line is read only after its tag has been installed and
	// the lookup repeated, long after the last beat was written
	// The byte lane of the fetch address plays no part here

endmodule

// File: src/icache_refill.sv
/* Instruction cache controller
   Sequences fetch lookups, picks the victim way and refills missing lines from memory */

`timescale 1ns/1ps

module icache_refill (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              fetch_req,
	input  icache_pkg::fetch_addr_t           fetch_addr,
	input  logic                              invalidate,
	input  logic                              ihit,
	input  icache_pkg::way_t                  hit_way,
	input  icache_pkg::tag_t                  victim_tag,
	input  logic                              victim_valid,
	input  logic [31:0]                       rdata,
	input  logic                              mem_valid,
	input  logic [31:0]                       mem_data,
	input  logic [icache_pkg::lines-1:0]      valid [0:icache_pkg::ways-1],
	output logic                              ready,
	output icache_pkg::fetch_addr_t           lookup_addr,
	output logic                              fetch_valid,
	output logic [31:0]                       fetch_data,
	output icache_pkg::way_t                  fetch_way,
	output icache_pkg::way_t                  victim_way,
	output logic                              mem_req,
	output logic [icache_pkg::awid-1:0]       mem_addr,
	output logic                              evict_valid,
	output icache_pkg::tag_t                  evict_tag,
	output logic [icache_pkg::index_bits-1:0] evict_index,
	output logic                              tag_we,
	output icache_pkg::way_t                  tag_way,
	output logic [icache_pkg::index_bits-1:0] tag_index,
	output icache_pkg::tag_t                  tag_value,
	output logic                              data_we,
	output icache_pkg::way_t                  data_way,
	output logic [icache_pkg::index_bits-1:0] data_index,
	output logic [icache_pkg::word_bits-1:0]  data_word,
	output logic [31:0]                       wdata
);

	import icache_pkg::*;

	logic [state_bits-1:0] state;
	// Set in the second cycle of qualify, when ihit is trustworthy
	logic                  qual_second;
	// Memory beats received for the current fill
	logic [word_bits-1:0]  beat_cnt;
	// Way being refilled and whether it held a valid line
	way_t                  fill_way;
	logic                  fill_replace;
	// Round-robin replacement pointer for each set
	way_t                  rr_ptr [0:lines-1];

	// ============================================================
	// Main FSM
	// ============================================================

	// Hit timing from the request edge 0
	// compare in cycle 1, qualify in cycles 2 and 3, read in cycle 4,
	// fetch_valid and ready after edge 4
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state       <= st_idle;
			qual_second <= 1'b0;
			beat_cnt    <= '0;
			fetch_valid <= 1'b0;
		end
		else
		begin
			fetch_valid <= 1'b0;
			case (state)
				st_idle:
					if (fetch_req)
						state <= st_compare;
				// Both enter the same two-cycle qualification
				st_compare, st_relookup:
				begin
					qual_second <= 1'b0;
					state       <= st_qualify;
				end
				st_qualify:
					if (!qual_second)
						qual_second <= 1'b1;
					else if (ihit)
						state <= st_read;
					else
					begin
						beat_cnt <= '0;
						state    <= st_request;
					end
				st_read:
				begin
					fetch_valid <= 1'b1;
					state       <= st_idle;
				end
				st_request:
					state <= st_fill;
				// Memory sends the words of the line in order
				st_fill:
					if (mem_valid)
					begin
						beat_cnt <= beat_cnt + 1'b1;
						if (beat_cnt == word_bits'(words_per_line - 1))
							state <= st_install;
					end
				st_install:
					state <= st_relookup;
				default:
					state <= st_idle;
			endcase
		end
	end

	// Address, returned word and refill choice
	always_ff @(posedge clk)
	begin
		if (state == st_idle && fetch_req)
			lookup_addr <= fetch_addr;
		if (state == st_read)
		begin
			fetch_data <= rdata;
			fetch_way  <= hit_way;
		end
		// The victim is frozen when the miss is decided
		if (state == st_qualify && qual_second && !ihit)
		begin
			fill_way     <= victim_way;
			fill_replace <= victim_valid;
		end
	end

	// ============================================================
	// Victim choice
	// ============================================================

	// The lowest invalid way of the set wins
	// With a full set the round-robin pointer names the victim
	always_comb
	begin
		victim_way = rr_ptr[lookup_addr.fields.index];
		for (int w = ways - 1; w >= 0; w--)
			if (!valid[w][lookup_addr.fields.index])
				victim_way = way_t'(w);
	end

	// The pointer only moves when a valid line of its set is replaced
	// An accepted invalidate restarts every set at way 0
	always_ff @(posedge clk)
	begin
		if (reset || (invalidate && state == st_idle))
			for (int i = 0; i < lines; i++)
				rr_ptr[i] <= '0;
		else if (state == st_install && fill_replace)
			rr_ptr[lookup_addr.fields.index] <= way_t'(rr_ptr[lookup_addr.fields.index] + 1'b1);
	end

	// ============================================================
	// Port outputs
	// ============================================================

	assign ready   = (state == st_idle);
	assign mem_req = (state == st_request);
	// Line address is the byte address with the 64-byte offset cleared
	assign mem_addr = {lookup_addr.raw[awid-1:6], 6'd0};

	// Eviction report goes out together with the memory request
	assign evict_valid = (state == st_request) && fill_replace;
	assign evict_tag   = victim_tag;
	assign evict_index = lookup_addr.fields.index;

	assign tag_we    = (state == st_install);
	assign tag_way   = fill_way;
	assign tag_index = lookup_addr.fields.index;
	assign tag_value = lookup_addr.fields.tag;

	assign data_we    = (state == st_fill) && mem_valid;
	assign data_way   = fill_way;
	assign data_index = lookup_addr.fields.index;
	assign data_word  = beat_cnt;
	assign wdata      = mem_data;

endmodule

// File: src/icache_top.sv
/* Four-way instruction cache top level
   Joins the tag store, hit detector, data store and controller to the fetch and memory ports */

`timescale 1ns/1ps

module icache_top (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              fetch_req,
	input  icache_pkg::fetch_addr_t           fetch_addr,
	input  logic                              invalidate,
	input  logic                              mem_valid,
	input  logic [31:0]                       mem_data,
	output logic                              ready,
	output logic                              fetch_valid,
	output logic [31:0]                       fetch_data,
	output icache_pkg::way_t                  fetch_way,
	output logic                              mem_req,
	output logic [31:0]                       mem_addr,
	output logic                              evict_valid,
	output icache_pkg::tag_t                  evict_tag,
	output logic [6:0]                        evict_index
);

	import icache_pkg::*;

	// Lookup address held by the controller
	fetch_addr_t           lookup_addr;
	// Tag store contents
	tag_t                  tags [0:ways-1][0:lines-1];
	logic [lines-1:0]      valid [0:ways-1];
	// Tag install from the controller
	logic                  tag_we;
	way_t                  tag_way;
	logic [index_bits-1:0] tag_index;
	tag_t                  tag_value;
	// Detector results
	logic                  ihit;
	way_t                  hit_way;
	tag_t                  victim_tag;
	logic                  victim_valid;
	way_t                  victim_way;
	// Data store write and read
	logic                  data_we;
	way_t                  data_way;
	logic [index_bits-1:0] data_index;
	logic [word_bits-1:0]  data_word;
	logic [31:0]           wdata;
	logic [31:0]           rdata;

	// ============================================================
	// Storage and hit detection
	// ============================================================

	// An invalidate only takes effect while the cache is ready
	icache_tag_ram u_tag_ram (
		.clk        (clk),
		.reset      (reset),
		.invalidate (invalidate & ready),
		.tag_we     (tag_we),
		.tag_way    (tag_way),
		.tag_index  (tag_index),
		.tag_value  (tag_value),
		.tags       (tags),
		.valid      (valid)
	);

	icache_hit_detect u_hit_detect (
		.clk          (clk),
		.reset        (reset),
		.lookup_addr  (lookup_addr),
		.tags         (tags),
		.valid        (valid),
		.victim_way   (victim_way),
		.ihit         (ihit),
		.hit_way      (hit_way),
		.victim_tag   (victim_tag),
		.victim_valid (victim_valid)
	);

	icache_data_ram u_data_ram (
		.clk         (clk),
		.data_we     (data_we),
		.data_way    (data_way),
		.data_index  (data_index),
		.data_word   (data_word),
		.wdata       (wdata),
		.lookup_addr (lookup_addr),
		.hit_way     (hit_way),
		.rdata       (rdata)
	);

	// ============================================================
	// Controller
	// ============================================================

	icache_refill u_refill (
		.clk          (clk),
		.reset        (reset),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.invalidate   (invalidate),
		.ihit         (ihit),
		.hit_way      (hit_way),
		.victim_tag   (victim_tag),
		.victim_valid (victim_valid),
		.rdata        (rdata),
		.mem_valid    (mem_valid),
		.mem_data     (mem_data),
		.valid        (valid),
		.ready        (ready),
		.lookup_addr  (lookup_addr),
		.fetch_valid  (fetch_valid),
		.fetch_data   (fetch_data),
		.fetch_way    (fetch_way),
		.victim_way   (victim_way),
		.mem_req      (mem_req),
		.mem_addr     (mem_addr),
		.evict_valid  (evict_valid),
		.evict_tag    (evict_tag),
		.evict_index  (evict_index),
		.tag_we       (tag_we),
		.tag_way      (tag_way),
		.tag_index    (tag_index),
		.tag_value    (tag_value),
		.data_we      (data_we),
		.data_way     (data_way),
		.data_index   (data_index),
		.data_word    (data_word),
		.wdata        (wdata)
	);

endmodule

// File: verification/icache_chk.sv
/* Instruction cache protocol checker
   Assertions on the fetch and memory strobes, bound into the cache top level */

`timescale 1ns/1ps

module icache_chk (
	input logic        clk,
	input logic        reset,
	input logic        fetch_req,
	input logic        ready,
	input logic        fetch_valid,
	input logic        mem_req,
	input logic [31:0] mem_addr,
	input logic        mem_valid
);

	// Beats still owed by memory for the fill in progress
	logic [4:0] beats_left;

	always_ff @(posedge clk)
	begin
		if (reset)
			beats_left <= 5'd0;
		else if (mem_req)
			beats_left <= 5'd16;
		else if (mem_valid && beats_left != 5'd0)
			beats_left <= beats_left - 5'd1;
	end

	// ============================================================
	// Strobe rules
	// ============================================================

	// The core must not request while a lookup or refill is running
	req_while_ready: assert property (@(posedge clk) disable iff (reset) fetch_req |-> ready)
		else $error("fetch request arrived while the cache was busy");

	mem_req_pulse: assert property (@(posedge clk) disable iff (reset) mem_req |=> !mem_req)
		else $error("memory request held for more than one cycle");

	// Line requests are always aligned to the 64 byte line
	mem_addr_aligned: assert property (@(posedge clk) disable iff (reset)
		mem_req |-> (mem_addr[5:0] == 6'd0))
		else $error("memory request address is not line aligned");

	fetch_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		fetch_valid |=> !fetch_valid)
		else $error("fetch_valid held for more than one cycle");

	// Only one miss may be outstanding at a time
	one_fill: assert property (@(posedge clk) disable iff (reset)
		mem_req |-> (beats_left == 5'd0))
		else $error("memory request issued while a fill was still outstanding");

endmodule

bind icache_top icache_chk u_chk (
	.clk         (clk),
	.reset       (reset),
	.fetch_req   (fetch_req),
	.ready       (ready),
	.fetch_valid (fetch_valid),
	.mem_req     (mem_req),
	.mem_addr    (mem_addr),
	.mem_valid   (mem_valid)
);

// File: verification/icache_tb.sv
/* Instruction cache testbench
   Memory model with random beat gaps, stimulus table, reference model and result checks */

`timescale 1ns/1ps

module icache_tb;

	import icache_pkg::*;

	localparam int          num_entries = 20;
	localparam int          ready_limit = 50;
	localparam int          fetch_limit = 300;
	localparam logic [31:0] data_key    = 32'h5a5a0000;

	logic        clk;
	logic        reset;
	logic        fetch_req;
	fetch_addr_t fetch_addr;
	logic        invalidate;
	logic        mem_valid = 1'b0;
	logic [31:0] mem_data  = 32'd0;
	logic        ready;
	logic        fetch_valid;
	logic [31:0] fetch_data;
	way_t        fetch_way;
	logic        mem_req;
	logic [31:0] mem_addr;
	logic        evict_valid;
	tag_t        evict_tag;
	logic [6:0]  evict_index;

	// Stimulus table, one row per fetch or invalidate
	logic        tbl_inval [0:num_entries-1];
	logic [31:0] tbl_addr  [0:num_entries-1];
	logic        tbl_hit   [0:num_entries-1];
	logic        tbl_evict [0:num_entries-1];
	tag_t        tbl_evtag [0:num_entries-1];

	// Reference model of the tag store and the replacement pointers
	logic        ref_valid [0:ways-1][0:lines-1];
	tag_t        ref_tag   [0:ways-1][0:lines-1];
	way_t        ref_rr    [0:lines-1];

	logic [31:0] lfsr = 32'h2b370d39;
	int          errors = 0;
	int          checks = 0;
	int          cur_entry = 0;
	// Strobe observations collected on falling edges
	int          mem_req_count = 0;
	logic [31:0] last_mem_addr;
	int          evict_count = 0;
	tag_t        last_evict_tag;
	logic [6:0]  last_evict_index;

	icache_top DUT (
		.clk         (clk),
		.reset       (reset),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.invalidate  (invalidate),
		.mem_valid   (mem_valid),
		.mem_data    (mem_data),
		.ready       (ready),
		.fetch_valid (fetch_valid),
		.fetch_data  (fetch_data),
		.fetch_way   (fetch_way),
		.mem_req     (mem_req),
		.mem_addr    (mem_addr),
		.evict_valid (evict_valid),
		.evict_tag   (evict_tag),
		.evict_index (evict_index)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ============================================================
	// Random source and memory model
	// ============================================================

	// Galois LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s >> 1;
		if (s[0])
			lfsr_step = lfsr_step ^ 32'h80200003;
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr  = lfsr_step(lfsr);
		end
	endtask

	// Sixteen beats in word order, each after a gap of 0 to 3 cycles
	task automatic serve_line(input logic [31:0] line_addr);
		int gap;
		for (int b = 0; b < words_per_line; b++)
		begin
			take_bits(2, gap);
			repeat (gap)
			begin
				@(posedge clk);
				mem_valid <= 1'b0;
			end
			@(posedge clk);
			mem_valid <= 1'b1;
			mem_data  <= (line_addr + 32'(4 * b)) ^ data_key;
		end
		@(posedge clk);
		mem_valid <= 1'b0;
	endtask

	always @(negedge clk)
	begin
		if (mem_req)
			serve_line(mem_addr);
	end

	always @(negedge clk)
	begin
		if (mem_req)
		begin
			mem_req_count++;
			last_mem_addr = mem_addr;
		end
		if (evict_valid)
		begin
			evict_count++;
			last_evict_tag   = evict_tag;
			last_evict_index = evict_index;
		end
	end

	// ============================================================
	// Table, reference model and checks
	// ============================================================

	task automatic add_entry(input int e, input bit inval, input tag_t tag, input int index,
		input int word, input bit hit, input bit evict, input tag_t evtag);
		tbl_inval[e] = inval;
		tbl_addr[e]  = {tag, 7'(index), 4'(word), 2'b00};
		tbl_hit[e]   = hit;
		tbl_evict[e] = evict;
		tbl_evtag[e] = evtag;
	endtask

	task automatic load_table();
		// Cold miss, then hits to the same line
		add_entry(0, 0, 19'h00001, 5, 3, 0, 0, 19'h0);
		add_entry(1, 0, 19'h00001, 5, 3, 1, 0, 19'h0);
		add_entry(2, 0, 19'h00001, 5, 10, 1, 0, 19'h0);
		// Five tags in set 20
		// The fifth and sixth replace ways 0 and 1
		add_entry(3, 0, 19'h00002, 20, 0, 0, 0, 19'h0);
		add_entry(4, 0, 19'h00003, 20, 1, 0, 0, 19'h0);
		add_entry(5, 0, 19'h00004, 20, 2, 0, 0, 19'h0);
		add_entry(6, 0, 19'h00005, 20, 3, 0, 0, 19'h0);
		add_entry(7, 0, 19'h00006, 20, 4, 0, 1, 19'h00002);
		add_entry(8, 0, 19'h00002, 20, 5, 0, 1, 19'h00003);
		add_entry(9, 0, 19'h00005, 20, 7, 1, 0, 19'h0);
		// Everything misses again after an invalidate
		add_entry(10, 1, 19'h0, 0, 0, 0, 0, 19'h0);
		add_entry(11, 0, 19'h00001, 5, 3, 0, 0, 19'h0);
		add_entry(12, 0, 19'h00006, 20, 0, 0, 0, 19'h0);
		add_entry(13, 0, 19'h00001, 5, 15, 1, 0, 19'h0);
		add_entry(14, 0, 19'h00006, 20, 9, 1, 0, 19'h0);
		add_entry(15, 0, 19'h7ffff, 127, 8, 0, 0, 19'h0);
		add_entry(16, 0, 19'h7ffff, 127, 0, 1, 0, 19'h0);
		add_entry(17, 0, 19'h12345, 0, 12, 0, 0, 19'h0);
		add_entry(18, 0, 19'h12345, 0, 1, 1, 0, 19'h0);
		add_entry(19, 0, 19'h00002, 20, 14, 0, 0, 19'h0);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] entry %0d %s: got 0x%h, expected 0x%h", cur_entry, name, got, exp);
		end
	endtask

	// Lookup and install in the model
	// The first free way is filled before any replacement
	task automatic model_fetch(input logic [31:0] addr, output bit hit, output way_t way,
		output bit evict, output tag_t ev_tag);
		fetch_addr_t a;
		bit          found;
		a.raw  = addr;
		hit    = 1'b0;
		evict  = 1'b0;
		ev_tag = '0;
		found  = 1'b0;
		way    = ref_rr[a.fields.index];
		for (int w = 0; w < ways; w++)
		begin
			if (ref_valid[w][a.fields.index] && ref_tag[w][a.fields.index] == a.fields.tag)
			begin
				hit = 1'b1;
				way = way_t'(w);
			end
		end
		if (!hit)
		begin
			for (int w = 0; w < ways; w++)
			begin
				if (!found && !ref_valid[w][a.fields.index])
				begin
					found = 1'b1;
					way   = way_t'(w);
				end
			end
			if (!found)
			begin
				evict  = 1'b1;
				ev_tag = ref_tag[way][a.fields.index];
				ref_rr[a.fields.index] = way_t'(ref_rr[a.fields.index] + 2'd1);
			end
			ref_valid[way][a.fields.index] = 1'b1;
			ref_tag[way][a.fields.index]   = a.fields.tag;
		end
	endtask

	task automatic wait_ready(output bit ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (!ok && n < ready_limit)
		begin
			@(negedge clk);
			n++;
			ok = ready;
		end
		if (!ok)
		begin
			errors++;
			$display("Timeout: ready stayed low before entry %0d", cur_entry);
		end
	endtask

	task automatic run_invalidate();
		@(posedge clk);
		invalidate <= 1'b1;
		@(posedge clk);
		invalidate <= 1'b0;
		for (int i = 0; i < lines; i++)
		begin
			for (int w = 0; w < ways; w++)
				ref_valid[w][i] = 1'b0;
			ref_rr[i] = '0;
		end
	endtask

	task automatic run_fetch(input logic [31:0] addr, output bit ok);
		bit   exp_hit;
		way_t exp_way;
		bit   exp_evict;
		tag_t exp_tag;
		int   req_before;
		int   evict_before;
		int   cycles;
		model_fetch(addr, exp_hit, exp_way, exp_evict, exp_tag);
		if (exp_hit != tbl_hit[cur_entry] || exp_evict != tbl_evict[cur_entry] ||
			(exp_evict && exp_tag != tbl_evtag[cur_entry]))
		begin
			errors++;
			$display("Reference model and stimulus table disagree at entry %0d", cur_entry);
		end
		req_before   = mem_req_count;
		evict_before = evict_count;
		@(posedge clk);
		fetch_req      <= 1'b1;
		fetch_addr.raw <= addr;
		@(posedge clk);
		fetch_req <= 1'b0;
		// Count falling edges from the request edge until the word is delivered
		cycles = 0;
		ok     = 1'b0;
		while (!ok && cycles < fetch_limit)
		begin
			@(negedge clk);
			cycles++;
			ok = fetch_valid;
		end
		if (!ok)
		begin
			errors++;
			$display("Timeout: no fetch_valid for entry %0d", cur_entry);
		end
		else
		begin
			check_value("fetch_data", fetch_data, (addr & 32'hffff_fffc) ^ data_key);
			check_value("fetch_way", 32'(fetch_way), 32'(exp_way));
			// The cache is ready again in the cycle the word is delivered
			check_value("ready", 32'(ready), 32'd1);
			check_value("mem_req count", 32'(mem_req_count - req_before),
				tbl_hit[cur_entry] ? 0 : 1);
			check_value("evict_valid count", 32'(evict_count - evict_before),
				tbl_evict[cur_entry] ? 1 : 0);
			if (tbl_hit[cur_entry])
				check_value("fetch_valid latency", 32'(cycles - 1), 32'd4);
			else
				check_value("mem_addr", last_mem_addr, addr & 32'hffff_ffc0);
			if (tbl_evict[cur_entry])
			begin
				check_value("evict_tag", 32'(last_evict_tag), 32'(tbl_evtag[cur_entry]));
				check_value("evict_index", 32'(last_evict_index), 32'(addr[12:6]));
			end
		end
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial
	begin
		bit ok;
		reset      = 1'b1;
		fetch_req  = 1'b0;
		fetch_addr = '0;
		invalidate = 1'b0;
		for (int i = 0; i < lines; i++)
		begin
			for (int w = 0; w < ways; w++)
				ref_valid[w][i] = 1'b0;
			ref_rr[i] = '0;
		end
		load_table();
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("ready", 32'(ready), 32'd1);
		check_value("fetch_valid", 32'(fetch_valid), 32'd0);
		check_value("mem_req", 32'(mem_req), 32'd0);
		check_value("evict_valid", 32'(evict_valid), 32'd0);
		ok = 1'b1;
		while (ok && cur_entry < num_entries)
		begin
			wait_ready(ok);
			if (ok && tbl_inval[cur_entry])
				run_invalidate();
			else if (ok)
				run_fetch(tbl_addr[cur_entry], ok);
			cur_entry++;
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: icache_top.f
src/icache_pkg.sv
src/icache_tag_ram.sv
src/icache_hit_detect.sv
src/icache_data_ram.sv
src/icache_refill.sv
src/icache_top.sv
verification/icache_chk.sv
verification/icache_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the instruction cache testbench
# Any variable can be overridden on the command line, e.g. make LOG=run.log

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= icache_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The result is taken from the log, a run that stops early has no pass line
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
